// File: addr_demux.sv
/*
 * Address demultiplexer
 * Registers the tile enable, decodes the slave port address and
 * steers the request to one scratchpad bank, the L2 master port or
 * the unmapped-error path. Nothing leaves while the tile is disabled.
 */

`timescale 1ns/100ps

module addr_demux (
  input  logic                                  clk_i,
  input  logic                                  rstn_i,
  input  logic                                  tile_enable_i,
  input  logic                                  wb_cyc_i,
  input  logic                                  wb_stb_i,
  input  logic                                  wb_we_i,
  input  logic [tile_cfg_pkg::ADDR_W-1:0]       wb_adr_i,
  input  logic [tile_cfg_pkg::DATA_W-1:0]       wb_dat_i,
  input  logic [tile_cfg_pkg::SEL_W-1:0]        wb_sel_i,
  output logic [tile_cfg_pkg::N_BANKS-1:0]      bank_stb_o,
  output logic                                  bank_we_o,
  output logic [tile_cfg_pkg::WORD_IDX_W-1:0]   bank_word_o,
  output logic [tile_cfg_pkg::DATA_W-1:0]       bank_dat_o,
  output logic [tile_cfg_pkg::SEL_W-1:0]        bank_sel_o,
  output logic                                  none_stb_o,
  output logic                                  l2_cyc_o,
  output logic                                  l2_stb_o,
  output logic                                  l2_we_o,
  output logic [tile_cfg_pkg::ADDR_W-1:0]       l2_adr_o,
  output logic [tile_cfg_pkg::DATA_W-1:0]       l2_dat_o,
  output logic [tile_cfg_pkg::SEL_W-1:0]        l2_sel_o
);

  import tile_cfg_pkg::*;
  import tile_map_pkg::*;

  logic                  enable_q;  // Registered tile enable
  logic                  req_ok;    // Live request, tile running
  logic [BANK_IDX_W-1:0] bank_idx;
  target_e               tgt;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      enable_q <= 1'b0;
    end else begin
      enable_q <= tile_enable_i;  // One cycle late, holds traffic when low
    end
  end

  // Range decode against the tile map
  always_comb begin
    if (wb_adr_i >= L1_BASE && wb_adr_i <= L1_END) begin
      tgt = TGT_L1;
    end else if (wb_adr_i >= L2_BASE && wb_adr_i <= L2_END) begin
      tgt = TGT_L2;
    end else begin
      tgt = TGT_NONE;
    end
  end

  assign req_ok   = wb_cyc_i & wb_stb_i & enable_q;
  assign bank_idx = wb_adr_i[BYTE_OFS_W +: BANK_IDX_W];  // Interleaved bank select

  // Bank side, one-hot strobe and shared payload
  assign bank_stb_o  = (req_ok && tgt == TGT_L1) ? (N_BANKS'(1) << bank_idx) : '0;
  assign bank_word_o = wb_adr_i[BYTE_OFS_W + BANK_IDX_W +: WORD_IDX_W];
  assign bank_we_o   = wb_we_i;
  assign bank_dat_o  = wb_dat_i;
  assign bank_sel_o  = wb_sel_i;

  assign none_stb_o = req_ok && tgt == TGT_NONE;  // Turned into err by resp_mux

  // L2 master port, strobe follows the slave strobe combinationally
  assign l2_cyc_o = wb_cyc_i & enable_q & (tgt == TGT_L2);
  assign l2_stb_o = req_ok && tgt == TGT_L2;
  assign l2_we_o  = wb_we_i;
  assign l2_adr_o = wb_adr_i;
  assign l2_dat_o = wb_dat_i;
  assign l2_sel_o = wb_sel_i;

endmodule

// File: mem_tile_sva.sv
/*
 * Protocol assertions for the tile memory subsystem
 * Bound to mem_tile_top, checks the response and L2 strobe rules.
 */

`timescale 1ns/100ps

module mem_tile_sva (
  input logic                            clk_i,
  input logic                            rstn_i,
  input logic                            wb_stb_i,
  input logic                            wb_ack_o,
  input logic                            wb_err_o,
  input logic                            l2_stb_o,
  input logic [tile_cfg_pkg::ADDR_W-1:0] l2_adr_o
);

  import tile_map_pkg::*;

  ack_err_excl: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !(wb_ack_o && wb_err_o))
    else $error("ack and err high in the same cycle");

  l2_stb_in_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
    l2_stb_o |-> (l2_adr_o >= L2_BASE && l2_adr_o <= L2_END))
    else $error("L2 strobe for address %h outside the L2 window", l2_adr_o);

  // Classic bus, the master still holds stb while ack is up
  ack_needs_stb: assert property (@(posedge clk_i) disable iff (!rstn_i)
    wb_ack_o |-> wb_stb_i)
    else $error("ack without a strobe on the slave port");

endmodule

bind mem_tile_top mem_tile_sva mem_tile_sva_i (
  .clk_i    (clk_i),
  .rstn_i   (rstn_i),
  .wb_stb_i (wb_stb_i),
  .wb_ack_o (wb_ack_o),
  .wb_err_o (wb_err_o),
  .l2_stb_o (l2_stb_o),
  .l2_adr_o (l2_adr_o)
);

// File: mem_tile_tb.sv
/*
 * Tile memory subsystem testbench
 * Random Wishbone traffic to the L1, L2 and unmapped ranges, checked
 * against an L1 reference array and an L2 responder model.
 */

`timescale 1ns/100ps

module mem_tile_tb;

  import tile_cfg_pkg::*;
  import tile_map_pkg::*;

  localparam int L1_WORDS = N_BANKS * WORDS_PER_BANK;
  localparam int TIMEOUT  = 50;  // Cycles allowed per response

  logic              clk;
  logic              rstn;
  logic              tile_en;
  logic              wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
  logic [ADDR_W-1:0] wb_adr, l2_adr;
  logic [DATA_W-1:0] wb_wdat, wb_rdat, l2_wdat, l2_rdat;
  logic [SEL_W-1:0]  wb_sel, l2_sel;
  logic              l2_cyc, l2_stb, l2_we, l2_ack, l2_err;

  integer            seed = 32'h5d1030c3;
  int                errors = 0;
  int                tests_ok = 0;
  logic [DATA_W-1:0] l1_ref [L1_WORDS];          // L1 contents by word offset
  logic [DATA_W-1:0] l2_mem [bit [ADDR_W-1:0]];  // L2 words by aligned address
  int                l2_delay = 1;               // Responder wait for the next access
  int                l2_wait = 0;
  int                l2_busy = 0;                // Edges with L2 cyc or stb high

  tb_clk_gen tb_clk_gen_i (.clk_o(clk));

  mem_tile_top mem_tile_top_i (
    .clk_i(clk), .rstn_i(rstn), .tile_enable_i(tile_en),
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_dat_i(wb_wdat), .wb_sel_i(wb_sel), .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack),
    .wb_err_o(wb_err), .l2_cyc_o(l2_cyc), .l2_stb_o(l2_stb), .l2_we_o(l2_we),
    .l2_adr_o(l2_adr), .l2_dat_o(l2_wdat), .l2_sel_o(l2_sel), .l2_dat_i(l2_rdat),
    .l2_ack_i(l2_ack), .l2_err_i(l2_err)
  );

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
      input logic [DATA_W-1:0] new_w, input logic [SEL_W-1:0] sel);
    for (int b = 0; b < SEL_W; b++) begin
      if (sel[b]) begin
        old_w[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return old_w;
  endfunction

  // Unwritten L2 words read as a pattern of their own address
  function automatic logic [DATA_W-1:0] l2_word(input logic [ADDR_W-1:0] adr);
    bit [ADDR_W-1:0] key;
    key = {adr[ADDR_W-1:2], 2'b00};
    return l2_mem.exists(key) ? l2_mem[key] : (key ^ 32'h5a5a_a5a5);
  endfunction

  // Any activity on the L2 master port
  always @(posedge clk) begin
    if (l2_cyc || l2_stb) begin
      l2_busy++;
    end
  end

  // L2 responder acks a held strobe after l2_delay cycles
  always @(posedge clk) begin
    if (l2_ack) begin
      l2_ack <= 1'b0;
    end else if (l2_stb) begin
      if (l2_wait < l2_delay) begin
        l2_wait++;
      end else begin
        l2_wait = 0;
        if (l2_cyc !== 1'b1 || l2_adr !== wb_adr || l2_we !== wb_we ||
            l2_wdat !== wb_wdat || l2_sel !== wb_sel) begin
          $display("mismatch at %0t: L2 port cyc %b adr %h we %b dat %h sel %h", $time,
                   l2_cyc, l2_adr, l2_we, l2_wdat, l2_sel);
          errors++;
        end
        if (l2_we) begin
          l2_mem[{l2_adr[ADDR_W-1:2], 2'b00}] = merge_bytes(l2_word(l2_adr), l2_wdat, l2_sel);
        end else begin
          l2_rdat <= l2_word(l2_adr);
        end
        l2_ack <= 1'b1;
      end
    end else begin
      l2_wait = 0;
    end
  end

  task automatic drive_req(input logic we, input logic [ADDR_W-1:0] adr,
                           input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel);
    wb_cyc  <= 1'b1;
    wb_stb  <= 1'b1;
    wb_we   <= we;
    wb_adr  <= adr;
    wb_wdat <= dat;
    wb_sel  <= sel;
  endtask

  // Edges are counted from the edge that drove the request
  task automatic wait_resp(output logic [DATA_W-1:0] rd, output logic ack, output logic err,
                           output int lat);
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!wb_ack && !wb_err && lat < TIMEOUT);
    rd  = wb_rdat;
    ack = wb_ack;
    err = wb_err;
    if (!ack && !err) begin
      $display("timeout at %0t: the tile gave no ack or err in %0d cycles", $time, TIMEOUT);
      errors++;
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    @(posedge clk);  // Response must be gone once the strobe is low
    if (wb_ack || wb_err) begin
      $display("mismatch at %0t: response held for more than one cycle", $time);
      errors++;
    end
  endtask

  task automatic access(input logic we, input logic [ADDR_W-1:0] adr,
                        input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                        output logic [DATA_W-1:0] rd, output logic ack, output logic err,
                        output int lat);
    drive_req(we, adr, dat, sel);
    wait_resp(rd, ack, err, lat);
  endtask

  task automatic expect_resp(input string what, input logic ack, input logic err, input int lat,
                             input logic want_ack, input int want_lat,
                             input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
    if (ack !== want_ack || err !== !want_ack) begin
      $display("mismatch at %0t: %s got ack %b err %b", $time, what, ack, err);
      errors++;
    end
    if (want_lat != 0 && lat != want_lat) begin
      $display("mismatch at %0t: %s answered after %0d edges, expected %0d", $time, what,
               lat, want_lat);
      errors++;
    end
    if (got !== exp) begin
      $display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int mark);
    if (errors == mark) begin
      tests_ok++;
    end
    $display("%-24s %s, %0d errors", name, (errors == mark) ? "ok" : "FAIL", errors - mark);
  endtask

  initial begin
    logic [DATA_W-1:0] rd, wd, exp_d;
    logic [ADDR_W-1:0] adr;
    logic [SEL_W-1:0]  sel;
    logic              we, ack, err;
    int                lat, idx, mark, strobes;
    rstn    = 1'b0;
    tile_en = 1'b0;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_wdat = '0;
    wb_sel  = '0;
    l2_rdat = '0;
    l2_ack  = 1'b0;
    l2_err  = 1'b0;
    repeat (2) @(posedge clk);
    rstn    <= 1'b1;
    tile_en <= 1'b1;
    @(posedge clk);

    // Fill every L1 word before mixed random reads and writes
    mark    = errors;
    strobes = l2_busy;
    for (int i = 0; i < L1_WORDS + 200; i++) begin
      idx   = (i < L1_WORDS) ? i : $unsigned($random(seed)) % L1_WORDS;
      we    = (i < L1_WORDS) || ($random(seed) & 1);
      wd    = $random(seed);
      adr   = L1_BASE + idx * 4;
      access(we, adr, wd, '1, rd, ack, err, lat);
      exp_d = we ? rd : l1_ref[idx];
      if (we) begin
        l1_ref[idx] = wd;
      end
      expect_resp("L1 word", ack, err, lat, 1'b1, 2, rd, exp_d);
    end
    if (l2_busy != strobes) begin
      $display("L2 cycle seen during L1 traffic");
      errors++;
    end
    end_test("L1 word access", mark);

    // Byte-select writes with a readback of each
    mark = errors;
    for (int i = 0; i < 100; i++) begin
      idx = $unsigned($random(seed)) % L1_WORDS;
      adr = L1_BASE + idx * 4;
      wd  = $random(seed);
      sel = $random(seed);
      access(1'b1, adr, wd, sel, rd, ack, err, lat);
      expect_resp("L1 byte write", ack, err, lat, 1'b1, 2, rd, rd);
      l1_ref[idx] = merge_bytes(l1_ref[idx], wd, sel);
      access(1'b0, adr, '0, '1, rd, ack, err, lat);
      expect_resp("L1 byte readback", ack, err, lat, 1'b1, 2, rd, l1_ref[idx]);
    end
    end_test("L1 byte select", mark);

    // L2 window through the responder with random latency
    mark    = errors;
    strobes = l2_busy;
    for (int i = 0; i < 80; i++) begin
      adr      = L2_BASE | ($random(seed) & 32'h0F00_00FC);
      we       = $random(seed) & 1;
      wd       = $random(seed);
      sel      = $random(seed);
      l2_delay = 1 + $unsigned($random(seed)) % 5;
      exp_d    = l2_word(adr);
      access(we, adr, wd, sel, rd, ack, err, lat);
      expect_resp("L2 access", ack, err, lat, 1'b1, l2_delay + 2, we ? exp_d : rd, exp_d);
    end
    if (l2_busy == strobes) begin
      $display("no L2 cycle during L2 traffic");
      errors++;
    end
    end_test("L2 forwarding", mark);

    // Unmapped addresses keep the top nibble away from both windows
    mark    = errors;
    strobes = l2_busy;
    for (int i = 0; i < 40; i++) begin
      adr = $random(seed);
      if (adr[31:28] == 4'h1 || adr[31:28] == 4'h8) begin
        adr[31:28] = 4'h4;
      end
      access($random(seed) & 1, adr, $random(seed), '1, rd, ack, err, lat);
      expect_resp("unmapped", ack, err, lat, 1'b0, 2, rd, rd);
    end
    if (l2_busy != strobes) begin
      $display("L2 cycle seen for an unmapped address");
      errors++;
    end
    end_test("unmapped error", mark);

    // Held request while the tile is disabled
    mark    = errors;
    tile_en <= 1'b0;
    @(posedge clk);
    idx = $unsigned($random(seed)) % L1_WORDS;
    adr = L1_BASE + idx * 4;
    wd  = $random(seed);
    drive_req(1'b1, adr, wd, '1);
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      if (wb_ack || wb_err) begin
        $display("mismatch at %0t: response while the tile is disabled", $time);
        errors++;
      end
    end
    tile_en <= 1'b1;
    wait_resp(rd, ack, err, lat);
    expect_resp("enable release", ack, err, lat, 1'b1, 3, rd, rd);  // Enable register adds one
    l1_ref[idx] = wd;
    access(1'b0, adr, '0, '1, rd, ack, err, lat);
    expect_resp("enable readback", ack, err, lat, 1'b1, 2, rd, l1_ref[idx]);
    end_test("tile enable hold", mark);

    $display("%0d of 5 tests ok, %0d errors", tests_ok, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: mem_tile_top.sv
/*
 * Tile memory subsystem
 * Wishbone classic slave port from the processor side, an address
 * demultiplexer, the interleaved scratchpad banks, a response
 * multiplexer and a Wishbone classic master port towards L2.
 */

`timescale 1ns/100ps

module mem_tile_top (
  input  logic                              clk_i,
  input  logic                              rstn_i,
  input  logic                              tile_enable_i,
  // Slave port, processor side
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [tile_cfg_pkg::ADDR_W-1:0]   wb_adr_i,
  input  logic [tile_cfg_pkg::DATA_W-1:0]   wb_dat_i,
  input  logic [tile_cfg_pkg::SEL_W-1:0]    wb_sel_i,
  output logic [tile_cfg_pkg::DATA_W-1:0]   wb_dat_o,
  output logic                              wb_ack_o,
  output logic                              wb_err_o,
  // Master port towards L2
  output logic                              l2_cyc_o,
  output logic                              l2_stb_o,
  output logic                              l2_we_o,
  output logic [tile_cfg_pkg::ADDR_W-1:0]   l2_adr_o,
  output logic [tile_cfg_pkg::DATA_W-1:0]   l2_dat_o,
  output logic [tile_cfg_pkg::SEL_W-1:0]    l2_sel_o,
  input  logic [tile_cfg_pkg::DATA_W-1:0]   l2_dat_i,
  input  logic                              l2_ack_i,
  input  logic                              l2_err_i
);

  import tile_cfg_pkg::*;

  logic [N_BANKS-1:0]             bank_stb;   // One-hot bank select
  logic                           bank_we;
  logic [WORD_IDX_W-1:0]          bank_word;  // Shared row index
  logic [DATA_W-1:0]              bank_wdat;
  logic [SEL_W-1:0]               bank_sel;
  logic [N_BANKS-1:0]             bank_ack;
  logic [N_BANKS-1:0][DATA_W-1:0] bank_rdat;  // Per-bank read data
  logic                           none_stb;

  addr_demux addr_demux_i (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .tile_enable_i (tile_enable_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_sel_i      (wb_sel_i),
    .bank_stb_o    (bank_stb),
    .bank_we_o     (bank_we),
    .bank_word_o   (bank_word),
    .bank_dat_o    (bank_wdat),
    .bank_sel_o    (bank_sel),
    .none_stb_o    (none_stb),
    .l2_cyc_o      (l2_cyc_o),
    .l2_stb_o      (l2_stb_o),
    .l2_we_o       (l2_we_o),
    .l2_adr_o      (l2_adr_o),
    .l2_dat_o      (l2_dat_o),
    .l2_sel_o      (l2_sel_o)
  );

  for (genvar g = 0; g < N_BANKS; g++) begin : gen_bank
    spm_bank spm_bank_i (
      .clk_i  (clk_i),
      .rstn_i (rstn_i),
      .stb_i  (bank_stb[g]),
      .we_i   (bank_we),
      .word_i (bank_word),
      .dat_i  (bank_wdat),
      .sel_i  (bank_sel),
      .ack_o  (bank_ack[g]),
      .dat_o  (bank_rdat[g])
    );
  end

  resp_mux resp_mux_i (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .bank_ack_i (bank_ack),
    .bank_dat_i (bank_rdat),
    .none_stb_i (none_stb),
    .l2_ack_i   (l2_ack_i),   // L2 response goes straight to the merge
    .l2_err_i   (l2_err_i),
    .l2_dat_i   (l2_dat_i),
    .wb_ack_o   (wb_ack_o),
    .wb_err_o   (wb_err_o),
    .wb_dat_o   (wb_dat_o)
  );

endmodule

// File: project.f
tile_cfg_pkg.sv
tile_map_pkg.sv
addr_demux.sv
spm_bank.sv
resp_mux.sv
mem_tile_top.sv
tb_clk_gen.sv
mem_tile_sva.sv
mem_tile_tb.sv

// File: resp_mux.sv
/*
 * Response multiplexer
 * Merges the bank acks, the L2 response and the unmapped-error
 * path onto the slave port. Read data follows the one-hot bank ack,
 * otherwise the L2 read data is passed through.
 */

`timescale 1ns/100ps

module resp_mux (
  input  logic                                                      clk_i,
  input  logic                                                      rstn_i,
  input  logic [tile_cfg_pkg::N_BANKS-1:0]                          bank_ack_i,
  input  logic [tile_cfg_pkg::N_BANKS-1:0][tile_cfg_pkg::DATA_W-1:0] bank_dat_i,
  input  logic                                                      none_stb_i,
  input  logic                                                      l2_ack_i,
  input  logic                                                      l2_err_i,
  input  logic [tile_cfg_pkg::DATA_W-1:0]                           l2_dat_i,
  output logic                                                      wb_ack_o,
  output logic                                                      wb_err_o,
  output logic [tile_cfg_pkg::DATA_W-1:0]                           wb_dat_o
);

  import tile_cfg_pkg::*;

  logic err_q;  // Error pulse for unmapped requests

  // Held none_stb gives one pulse, same rule as the banks
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= none_stb_i & ~err_q;
    end
  end

  // At most one bank acks at a time, L2 data is the default
  always_comb begin
    wb_dat_o = l2_dat_i;
    for (int n = 0; n < N_BANKS; n++) begin
      if (bank_ack_i[n]) begin
        wb_dat_o = bank_dat_i[n];
      end
    end
  end

  assign wb_ack_o = (|bank_ack_i) | l2_ack_i;  // L2 ack passes in the same cycle
  assign wb_err_o = err_q | l2_err_i;

endmodule

// File: spm_bank.sv
/*
 * Scratchpad bank
 * Single-port word memory with byte-enable writes. A strobe is
 * acknowledged one cycle later with registered read data; a strobe
 * held through its ack does not start a second access.
 */

`timescale 1ns/100ps

module spm_bank (
  input  logic                                clk_i,
  input  logic                                rstn_i,
  input  logic                                stb_i,
  input  logic                                we_i,
  input  logic [tile_cfg_pkg::WORD_IDX_W-1:0] word_i,
  input  logic [tile_cfg_pkg::DATA_W-1:0]     dat_i,
  input  logic [tile_cfg_pkg::SEL_W-1:0]      sel_i,
  output logic                                ack_o,
  output logic [tile_cfg_pkg::DATA_W-1:0]     dat_o
);

  import tile_cfg_pkg::*;

  logic [DATA_W-1:0] mem [WORDS_PER_BANK];  // Bank storage
  logic              ack_q;
  logic              access;                // New access this cycle

  assign access = stb_i & ~ack_q;  // Held strobe during ack is ignored

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;  // Single-cycle ack
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (we_i) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (sel_i[b]) begin
            mem[word_i][8*b +: 8] <= dat_i[8*b +: 8];  // Only selected bytes
          end
        end
      end else begin
        dat_o <= mem[word_i];  // Valid together with ack
      end
    end
  end

  assign ack_o = ack_q;

endmodule

// File: tb_clk_gen.sv
/*
 * Testbench clock source
 * Free-running clock with a 40 ns period.
 */

`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;  // Half period
  end

endmodule

// File: tile_cfg_pkg.sv
/*
 * Tile configuration package
 * Bus widths and the geometry of the word-interleaved scratchpad
 * bank array. Bank and word index widths are derived so that the
 * bank index sits directly above the byte offset of an address.
 */

package tile_cfg_pkg;

  // Bus widths
  localparam int unsigned DATA_W = 32;          // Wishbone data width
  localparam int unsigned ADDR_W = 32;          // Wishbone address width
  localparam int unsigned SEL_W  = DATA_W / 8;  // One select bit per byte

  // Scratchpad array shape
  localparam int unsigned N_BANKS        = 4;   // Banks in the L1 array
  localparam int unsigned WORDS_PER_BANK = 64;  // Depth of each bank

  // Address slicing, LSB first
  localparam int unsigned BYTE_OFS_W = 2;                        // Byte in word
  localparam int unsigned BANK_IDX_W = $clog2(N_BANKS);          // Interleave
  localparam int unsigned WORD_IDX_W = $clog2(WORDS_PER_BANK);   // Row in bank

  // Address layout inside the L1 window:
  //   [BYTE_OFS_W+BANK_IDX_W +: WORD_IDX_W]  word in bank
  //   [BYTE_OFS_W +: BANK_IDX_W]             bank
  //   [0 +: BYTE_OFS_W]                      byte, ignored by the banks
  // Consecutive words land in consecutive banks, so streaming accesses
  // spread across the whole array.

endpackage

// File: tile_map_pkg.sv
/*
 * Tile address map package
 * Address windows seen by the processor data port and the
 * target type that the request decoder produces.
 */

package tile_map_pkg;

  // L1 scratchpad window, sized by the bank array
  localparam logic [tile_cfg_pkg::ADDR_W-1:0] L1_BASE = 32'h1000_0000;
  localparam logic [tile_cfg_pkg::ADDR_W-1:0] L1_SIZE =
    tile_cfg_pkg::N_BANKS * tile_cfg_pkg::WORDS_PER_BANK * (tile_cfg_pkg::DATA_W / 8);
  localparam logic [tile_cfg_pkg::ADDR_W-1:0] L1_END  = L1_BASE + L1_SIZE - 1;  // 0x1000_03FF

  // L2 window, forwarded through the master port
  localparam logic [tile_cfg_pkg::ADDR_W-1:0] L2_BASE = 32'h8000_0000;
  localparam logic [tile_cfg_pkg::ADDR_W-1:0] L2_END  = 32'h8FFF_FFFF;

  // Where a request goes
  typedef enum logic [1:0] {
    TGT_L1   = 2'd0,  // Local bank array
    TGT_L2   = 2'd1,  // Out of the tile
    TGT_NONE = 2'd2   // Unmapped, answered with err
  } target_e;

endpackage
